// ==== keypad_pkg.sv ====
package keypad_pkg;

    localparam int KEY_ROWS = 4;
    localparam int KEY_COLS = 4;
    localparam int KEY_CODE_W = 4;

    localparam int DEBOUNCE_CYCLES = 16;    // Scaled down for simulation.

    localparam int QUEUE_DEPTH = 4;
    localparam int KEY_CREDITS = 2;         // Granted by the consumer at reset.

    localparam int COL_IDX_W = $clog2(KEY_COLS);
    localparam int DEB_CNT_W = $clog2(DEBOUNCE_CYCLES);
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CREDIT_W = $clog2(KEY_CREDITS + 1);

    // Row index times KEY_COLS plus column index.
    typedef logic [KEY_CODE_W-1:0] key_code_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SCAN1,
        ST_DEBOUNCE,
        ST_SCAN2,
        ST_JUDGE,
        ST_RELEASE
    } scan_state_t;

endpackage

// ==== coord_if.sv ====
`timescale 1ns/10ps

interface coord_if
    import keypad_pkg::*;
();

    logic                capture;   // One cycle per column hit.
    logic                second;    // Hit belongs to the second scan.
    logic [KEY_ROWS-1:0] row_bits;
    logic [KEY_COLS-1:0] col_bits;
    logic                accepted;  // Both scans agree on a legal key.

    modport ctrl (
        output capture,
        output second,
        output row_bits,
        output col_bits,
        input  accepted
    );

    modport decode (
        input  capture,
        input  second,
        input  row_bits,
        input  col_bits,
        output accepted
    );

endinterface

// ==== keypad_scan_ctrl.sv ====
`timescale 1ns/10ps

module keypad_scan_ctrl
    import keypad_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [KEY_ROWS-1:0] row_in,
    output logic [KEY_COLS-1:0] col_out,
    coord_if.ctrl               cif
);

    scan_state_t          state;
    logic [COL_IDX_W-1:0] col_idx;
    logic                 sample;     // Low on the settle cycle, high on the sample cycle.
    logic [DEB_CNT_W-1:0] deb_cnt;
    logic                 rows_idle;
    logic                 scanning;
    logic                 hit;
    logic                 last_col;
    logic                 deb_done;

    assign rows_idle = &row_in;
    assign scanning  = (state == ST_SCAN1) || (state == ST_SCAN2);
    assign hit       = scanning && sample && !rows_idle;
    assign last_col  = (col_idx == COL_IDX_W'(KEY_COLS - 1));
    assign deb_done  = (deb_cnt == DEB_CNT_W'(DEBOUNCE_CYCLES - 1));

    // A single column is pulled low while scanning, all of them otherwise.
    always_comb begin
        col_out = '0;
        if (scanning) begin
            col_out          = '1;
            col_out[col_idx] = 1'b0;
        end
    end

    assign cif.capture  = hit;
    assign cif.second   = (state == ST_SCAN2);
    assign cif.row_bits = row_in;
    assign cif.col_bits = col_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            col_idx <= '0;
            sample  <= 1'b0;
            deb_cnt <= '0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    col_idx <= '0;
                    sample  <= 1'b0;
                    deb_cnt <= '0;
                    if (!rows_idle) begin
                        state <= ST_SCAN1;
                    end
                end

                ST_SCAN1, ST_SCAN2: begin
                    if (!sample) begin
                        sample <= 1'b1;              // Rows settle on this cycle.
                    end else if (hit) begin
                        sample  <= 1'b0;
                        col_idx <= '0;
                        deb_cnt <= '0;
                        state   <= (state == ST_SCAN1) ? ST_DEBOUNCE : ST_JUDGE;
                    end else if (last_col) begin
                        sample <= 1'b0;
                        state  <= ST_IDLE;          // Key gone before it was found.
                    end else begin
                        col_idx <= col_idx + 1'b1;
                        sample  <= 1'b0;
                    end
                end

                ST_DEBOUNCE: begin
                    if (deb_done) begin
                        deb_cnt <= '0;
                        col_idx <= '0;
                        sample  <= 1'b0;
                        state   <= rows_idle ? ST_IDLE : ST_SCAN2;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end

                // Decoder answers on this cycle; a rejected press also waits for release.
                ST_JUDGE: begin
                    deb_cnt <= '0;
                    state   <= ST_RELEASE;
                end

                ST_RELEASE: begin
                    if (!rows_idle) begin
                        deb_cnt <= '0;               // Any bounce restarts the count.
                    end else if (deb_done) begin
                        deb_cnt <= '0;
                        state   <= ST_IDLE;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== key_decode.sv ====
`timescale 1ns/10ps

module key_decode
    import keypad_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    coord_if.decode   cif,
    output logic      push,
    output key_code_t push_code
);

    logic [KEY_ROWS-1:0] first_row;
    logic [KEY_COLS-1:0] first_col;
    logic                same_coord;
    logic                legal;
    key_code_t           code_q;

    // Position of the single low row and column.
    function automatic key_code_t encode_key(
        input logic [KEY_ROWS-1:0] rows,
        input logic [KEY_COLS-1:0] cols
    );
        key_code_t code;
        code = '0;
        for (int r = 0; r < KEY_ROWS; r++) begin
            for (int c = 0; c < KEY_COLS; c++) begin
                if (!rows[r] && !cols[c]) begin
                    code = key_code_t'(r * KEY_COLS + c);
                end
            end
        end
        return code;
    endfunction

    assign same_coord = (cif.row_bits == first_row) && (cif.col_bits == first_col);
    assign legal      = $onehot(~cif.row_bits) && $onehot(~cif.col_bits);

    always_ff @(posedge clk) begin
        if (cif.capture && !cif.second) begin
            first_row <= cif.row_bits;
            first_col <= cif.col_bits;
        end
        if (cif.capture && cif.second) begin
            code_q <= encode_key(cif.row_bits, cif.col_bits);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cif.accepted <= 1'b0;
        end else begin
            cif.accepted <= cif.capture && cif.second && same_coord && legal;
        end
    end

    assign push      = cif.accepted;
    assign push_code = code_q;

endmodule

// ==== key_queue.sv ====
`timescale 1ns/10ps

module key_queue
    import keypad_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push,
    input  key_code_t push_code,
    output logic      key_valid,
    output key_code_t key_code,
    input  logic      credit_return,
    output logic      overrun
);

    key_code_t           mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]   wr_ptr;
    logic [QPTR_W-1:0]   rd_ptr;
    logic [QCNT_W-1:0]   count;
    logic [CREDIT_W-1:0] credits;
    logic                full;
    logic                do_push;
    logic                pop;

    assign full      = (count == QCNT_W'(QUEUE_DEPTH));
    assign do_push   = push && !full;       // Full is judged before any pop this cycle.
    assign key_valid = (count != '0) && (credits != '0);
    assign pop       = key_valid;
    assign key_code  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CREDIT_W'(KEY_CREDITS);
            overrun <= 1'b0;
        end else begin
            overrun <= push && full;

            if (do_push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            unique case ({do_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // Return and spend may land on the same cycle.
            unique case ({credit_return, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== keypad_top.sv ====
`timescale 1ns/10ps

module keypad_top
    import keypad_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [KEY_ROWS-1:0] row_in,
    output logic [KEY_COLS-1:0] col_out,
    output logic                key_valid,
    output key_code_t           key_code,
    input  logic                credit_return,
    output logic                overrun
);

    coord_if   cif ();
    logic      push;
    key_code_t push_code;

    keypad_scan_ctrl scan_ctrl_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .row_in  (row_in),
        .col_out (col_out),
        .cif     (cif.ctrl)
    );

    key_decode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cif       (cif.decode),
        .push      (push),
        .push_code (push_code)
    );

    key_queue queue_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_code     (push_code),
        .key_valid     (key_valid),
        .key_code      (key_code),
        .credit_return (credit_return),
        .overrun       (overrun)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;    // 8 ns period.
        end
    end

endmodule

// ==== keypad_checker.sv ====
`timescale 1ns/10ps

module keypad_checker
    import keypad_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [KEY_COLS-1:0] col_out,
    input  logic                key_valid,
    input  key_code_t           key_code,
    input  logic                credit_return,
    input  logic                overrun,
    input  logic                exp_push,
    input  key_code_t           exp_code,
    output int                  pending,
    output int                  pending_overruns,
    output int                  value_errors,
    output int                  protocol_errors
);

    key_code_t exp_q [$];
    key_code_t front;
    int        occupancy = 0;     // Accepted presses minus deliveries.
    int        credits = KEY_CREDITS;
    int        lost_cnt = 0;
    int        value_cnt = 0;
    int        protocol_cnt = 0;
    int        pending_cnt = 0;
    bit        reset_checked = 1'b0;

    assign pending          = pending_cnt;
    assign pending_overruns = lost_cnt;
    assign value_errors     = value_cnt;
    assign protocol_errors  = protocol_cnt;

    // Sampled mid-cycle, where DUT outputs and stimulus have settled.
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            occupancy     = 0;
            credits       = KEY_CREDITS;
            lost_cnt      = 0;
            reset_checked = 1'b0;
        end else begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (key_valid || overrun || (col_out != '0)) begin
                    $display("FAILED at %0t: outputs not idle after reset", $time);
                    value_cnt++;
                end
            end
            if (exp_push) begin
                if (occupancy >= QUEUE_DEPTH) begin
                    lost_cnt++;                       // Queue full, key is dropped.
                end else begin
                    exp_q.push_back(exp_code);
                    occupancy++;
                end
            end
            if (key_valid) begin
                if (credits <= 0) begin
                    $display("Key delivered at %0t while the consumer held no credit", $time);
                    protocol_cnt++;
                end
                credits--;
                if (exp_q.size() == 0) begin
                    $display("Key %0d delivered at %0t with no confirmed press waiting",
                             key_code, $time);
                    protocol_cnt++;
                end else begin
                    front = exp_q.pop_front();
                    occupancy--;
                    if (key_code !== front) begin
                        $display("FAILED at %0t: key_code %0d, expected %0d",
                                 $time, key_code, front);
                        value_cnt++;
                    end
                end
            end
            if (credit_return) begin
                credits++;
            end
            if (overrun) begin
                if (lost_cnt == 0) begin
                    $display("Overrun raised at %0t although the queue had room", $time);
                    protocol_cnt++;
                end else begin
                    lost_cnt--;
                end
            end
        end
        pending_cnt = exp_q.size();
    end

endmodule

// ==== keypad_tb.sv ====
`timescale 1ns/10ps

module keypad_tb
    import keypad_pkg::*;
();

    logic                         clk;
    logic                         rst_n;
    logic [KEY_ROWS-1:0]          row_in;
    logic [KEY_COLS-1:0]          col_out;
    logic                         key_valid;
    key_code_t                    key_code;
    logic                         credit_return;
    logic                         overrun;

    logic [KEY_ROWS*KEY_COLS-1:0] pressed;       // One bit per key in row-major order.
    logic                         ret_en;        // Consumer may pay credits back.
    logic                         next_ret;
    logic                         exp_push;
    key_code_t                    exp_code;
    logic [31:0]                  lfsr_state;
    int                           outstanding;   // Codes taken whose credit is not yet back.
    int                           pending;
    int                           pending_overruns;
    int                           value_errors;
    int                           protocol_errors;
    int                           timeouts;
    int                           end_errors;
    int                           row;
    int                           col;
    int                           hold;
    int                           gap;
    int                           gap_ret;

    tb_clock_gen clock_i (.clk(clk));

    keypad_top keypad_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .row_in        (row_in),
        .col_out       (col_out),
        .key_valid     (key_valid),
        .key_code      (key_code),
        .credit_return (credit_return),
        .overrun       (overrun)
    );

    keypad_checker checker_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .col_out          (col_out),
        .key_valid        (key_valid),
        .key_code         (key_code),
        .credit_return    (credit_return),
        .overrun          (overrun),
        .exp_push         (exp_push),
        .exp_code         (exp_code),
        .pending          (pending),
        .pending_overruns (pending_overruns),
        .value_errors     (value_errors),
        .protocol_errors  (protocol_errors)
    );

    // A row reads low through any pressed key whose column is driven low.
    always_comb begin
        row_in = '1;
        for (int r = 0; r < KEY_ROWS; r++) begin
            for (int c = 0; c < KEY_COLS; c++) begin
                if (pressed[r*KEY_COLS+c] && !col_out[c]) begin
                    row_in[r] = 1'b0;
                end
            end
        end
    end

    // Consumer counts deliveries mid-cycle and returns one credit per cycle.
    initial begin
        credit_return = 1'b0;
        outstanding   = 0;
        next_ret      = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                outstanding = outstanding + (key_valid ? 1 : 0) - (credit_return ? 1 : 0);
            end
            next_ret = ret_en && (outstanding > 0);
            @(posedge clk);
            #1;
            credit_return = next_ret;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            next_cycle();
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken.
    function automatic int take_bits(input int n);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // Credits flow in the hold phase and the late gap only when hold_ret is set.
    task automatic press_keys(
        input logic [KEY_ROWS*KEY_COLS-1:0] keys,
        input int                           hold_len,
        input int                           gap_len,
        input bit                           expect_key,
        input key_code_t                    code,
        input bit                           hold_ret,
        input bit                           gap_ret
    );
        pressed  = keys;
        ret_en   = hold_ret;
        exp_push = expect_key;
        exp_code = code;
        next_cycle();
        exp_push = 1'b0;
        wait_cycles(hold_len - 1);
        pressed = '0;
        ret_en  = gap_ret;
        wait_cycles(DEBOUNCE_CYCLES);
        ret_en = hold_ret;
        wait_cycles(gap_len - DEBOUNCE_CYCLES);
    endtask

    task automatic press_rc(
        input int r,
        input int c,
        input int hold_len,
        input int gap_len,
        input bit hold_ret,
        input bit gap_ret
    );
        logic [KEY_ROWS*KEY_COLS-1:0] keys;
        keys                = '0;
        keys[r*KEY_COLS+c]  = 1'b1;
        press_keys(keys, hold_len, gap_len, 1'b1, key_code_t'(r * KEY_COLS + c),
                   hold_ret, gap_ret);
    endtask

    task automatic drain_queue(input int limit);
        int waited;
        waited = 0;
        ret_en = 1'b1;
        while (((pending != 0) || (outstanding != 0)) && (waited < limit)) begin
            next_cycle();
            waited++;
        end
        if ((pending != 0) || (outstanding != 0)) begin
            $display("Timed out at %0t waiting for the key queue to drain", $time);
            timeouts++;
        end
        wait_cycles(4);
    endtask

    initial begin
        rst_n      = 1'b0;
        pressed    = '0;
        ret_en     = 1'b0;
        exp_push   = 1'b0;
        exp_code   = '0;
        lfsr_state = 32'hf67c5bf0;
        timeouts   = 0;
        end_errors = 0;
        wait_cycles(5);
        rst_n = 1'b1;
        wait_cycles(4);

        press_rc(1, 2, DEBOUNCE_CYCLES + 20, 2 * DEBOUNCE_CYCLES, 1'b1, 1'b1);
        press_rc(0, 0, DEBOUNCE_CYCLES + 20, 2 * DEBOUNCE_CYCLES, 1'b1, 1'b1);
        press_rc(3, 3, DEBOUNCE_CYCLES + 20, 2 * DEBOUNCE_CYCLES, 1'b1, 1'b1);

        // Glitch on row 1 column 1 that is gone before the debounce ends.
        press_keys(16'h0020, DEBOUNCE_CYCLES / 3, 2 * DEBOUNCE_CYCLES, 1'b0, '0, 1'b1, 1'b1);

        // Long hold and then the same key again after a full release.
        press_rc(2, 1, 5 * DEBOUNCE_CYCLES, 2 * DEBOUNCE_CYCLES, 1'b1, 1'b1);
        press_rc(2, 1, DEBOUNCE_CYCLES + 20, 2 * DEBOUNCE_CYCLES, 1'b1, 1'b1);

        // Rows 0 and 1 together on column 1.
        press_keys(16'h0022, DEBOUNCE_CYCLES + 20, 2 * DEBOUNCE_CYCLES, 1'b0, '0, 1'b1, 1'b1);
        drain_queue(200);

        // With credits withheld two get through and four wait while the rest overrun.
        for (int i = 0; i < QUEUE_DEPTH + KEY_CREDITS + 2; i++) begin
            row = i % KEY_ROWS;
            col = (i / KEY_ROWS + i) % KEY_COLS;
            press_rc(row, col, DEBOUNCE_CYCLES + 20, 2 * DEBOUNCE_CYCLES, 1'b0, 1'b0);
        end
        drain_queue(400);

        for (int i = 0; i < 40; i++) begin
            row     = take_bits(2);                      // Row first and column second.
            col     = take_bits(2);
            hold    = DEBOUNCE_CYCLES + 20 + take_bits(5);
            gap     = 2 * DEBOUNCE_CYCLES + take_bits(4);
            gap_ret = take_bits(1);
            press_rc(row, col, hold, gap, 1'b0, gap_ret[0]);
        end
        drain_queue(400);
        wait_cycles(10);

        if (pending != 0) begin
            $display("Expected queue still holds %0d codes at the end of the run", pending);
            end_errors++;
        end
        if (pending_overruns != 0) begin
            $display("%0d predicted overruns never appeared", pending_overruns);
            end_errors++;
        end
        $display("Error counts: %0d value, %0d protocol, %0d timeout, %0d end of run",
                 value_errors, protocol_errors, timeouts, end_errors);
        if ((value_errors + protocol_errors + timeouts + end_errors) == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== files.f ====
keypad_pkg.sv
coord_if.sv
keypad_scan_ctrl.sv
key_decode.sv
key_queue.sv
keypad_top.sv
tb_clock_gen.sv
keypad_checker.sv
keypad_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module keypad_tb -f files.f -o keypad_sim

./obj_dir/keypad_sim > sim.log 2>&1
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
